/* common/isaPkg.sv */
// Instruction set definitions
`default_nettype none

package isaPkg;

   // instruction class, bits 7..3 of the opcode byte
   typedef enum logic [4:0] {
      ADD,
      ADDI,
      ADDIB,
      ADC,
      ADCI,
      SUB,
      SUBI,
      SUBIB,
      SUC,
      SUCI,
      NEG,
      CMP,
      CMPI,
      AND,
      OR,
      XOR,
      NOT,
      NAND,
      NOR,
      LSL,
      LSR,
      ASR,
      LUI,
      LLI,
      LDW,
      STW,
      BRANCH,
      INTERRUPT
   } opcodeT;

   // condition code, bits 2..0 of the opcode byte
   typedef enum logic [2:0] {
      BR, BNE, BE, BLT, BGE, BWL, RET, JMP
   } branchT;

   // the same field under INTERRUPT
   localparam branchT CodeEi = branchT'(3'd1);  // enable interrupts
   localparam branchT CodeDi = branchT'(3'd2);  // disable interrupts

   // bit positions in the flag word
   localparam int FlagC = 0;
   localparam int FlagZ = 1;
   localparam int FlagN = 2;
   localparam int FlagV = 3;
   localparam int FlagWidth = 4;

endpackage

`default_nettype wire

/* common/controlPkg.sv */
// Datapath control codes
`default_nettype none

package controlPkg;

   // ALU function select
   typedef enum logic [3:0] {
      FnA,     // pass operand 1
      FnADD,
      FnADC,
      FnSUB,
      FnNEG,
      FnAND,
      FnOR,
      FnXOR,
      FnNOT,
      FnNAND,
      FnNOR,
      FnLSL,
      FnLSR,
      FnASR,
      FnLUI,
      FnLLI
   } aluFnT;

   typedef enum logic {Op1Rd1, Op1Pc} op1SelT;
   typedef enum logic {Op2Imm, Op2Rd2} op2SelT;
   typedef enum logic {WdAlu, WdSys} wdSelT;     // register write data source
   typedef enum logic {ImmLong, ImmShort} immSelT;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus, PcInt} pcSelT;
   typedef enum logic {LrSys, LrPc} lrSelT;
   typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Seven} rs1SelT;  // seven is the stack pointer

   // control states
   typedef enum logic [1:0] {Fetch, Execute, Interrupt} majorStateT;
   typedef enum logic [2:0] {Cycle0, Cycle1, Cycle2, Cycle3, Cycle4} subCycleT;

endpackage

`default_nettype wire

/* source/interruptLatch.sv */
// Interrupt request latch
`timescale 1ns/1ns
`default_nettype none

module interruptLatch #(
   parameter int SyncStages = 2
) (
   input  wire  Clock,
   input  wire  nReset,
   input  wire  nIRQ,
   input  logic IntClear,
   input  logic IntEnable,
   input  logic IntDisable,
   output logic IntReq
);

   logic [SyncStages-1:0] syncReg;  // request in the core clock domain
   logic intStatus;                 // interrupts enabled

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         syncReg <= '0;
      end else begin
         syncReg[0] <= ~nIRQ;
         for (int i = 1; i < SyncStages; i++) begin
            syncReg[i] <= syncReg[i-1];
         end
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         IntReq <= 1'b0;
         intStatus <= 1'b0;
      end else begin
         if (syncReg[SyncStages-1] && intStatus) begin
            IntReq <= 1'b1;
         end else if (IntClear) begin
            IntReq <= 1'b0;     // entry sequence done
         end
         if (IntEnable) begin
            intStatus <= 1'b1;
         end else if (IntDisable) begin
            intStatus <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* source/statusFlags.sv */
// Status register and branch test
`timescale 1ns/1ns
`default_nettype none

module statusFlags (
   input  wire                          Clock,
   input  wire                          nReset,
   input  wire  [isaPkg::FlagWidth-1:0] Flags,
   input  logic                         StatusWe,
   input  isaPkg::branchT               Branch,
   output logic                         BranchTaken,
   output logic                         CFlag
);

   logic [isaPkg::FlagWidth-1:0] statusReg;
   logic nDiffV;  // N equals V

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (StatusWe) begin
         statusReg <= Flags;
      end
   end

   assign CFlag = statusReg[isaPkg::FlagC];
   assign nDiffV = statusReg[isaPkg::FlagN] == statusReg[isaPkg::FlagV];

   always_comb begin
      case (Branch)
         isaPkg::BR, isaPkg::BWL: BranchTaken = 1'b1;
         isaPkg::BNE: BranchTaken = !statusReg[isaPkg::FlagZ];
         isaPkg::BE:  BranchTaken = statusReg[isaPkg::FlagZ];
         isaPkg::BLT: BranchTaken = !nDiffV;  // signed less than
         isaPkg::BGE: BranchTaken = nDiffV;
         default:     BranchTaken = 1'b0;     // ret and jmp decoded elsewhere
      endcase
   end

endmodule

`default_nettype wire

/* sequencer/stateSequencer.sv */
// Control state sequencer
`timescale 1ns/1ns
`default_nettype none

module stateSequencer (
   input  wire                    Clock,
   input  wire                    nReset,
   input  isaPkg::opcodeT         Opcode,
   input  isaPkg::branchT         Branch,
   input  logic                   IntReq,
   output controlPkg::majorStateT MajorState,
   output controlPkg::subCycleT   SubCycle
);

   logic longOp;  // five cycle execute
   controlPkg::subCycleT nextSub;

   assign longOp = (Opcode == isaPkg::LDW) || (Opcode == isaPkg::STW);
   assign nextSub = controlPkg::subCycleT'(SubCycle + 3'd1);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         MajorState <= controlPkg::Fetch;
         SubCycle <= controlPkg::Cycle0;
      end else begin
         case (MajorState)
            controlPkg::Fetch: begin
               if (SubCycle == controlPkg::Cycle0 && IntReq) begin
                  MajorState <= controlPkg::Interrupt;  // take it before the next load
               end else if (SubCycle == controlPkg::Cycle3) begin
                  MajorState <= controlPkg::Execute;
                  SubCycle <= controlPkg::Cycle0;
               end else begin
                  SubCycle <= nextSub;
               end
            end
            controlPkg::Execute: begin
               if (SubCycle == controlPkg::Cycle4 ||
                   (SubCycle == controlPkg::Cycle0 && !longOp)) begin
                  MajorState <= controlPkg::Fetch;
                  SubCycle <= controlPkg::Cycle0;
               end else begin
                  SubCycle <= nextSub;
               end
            end
            controlPkg::Interrupt: begin
               if (SubCycle == controlPkg::Cycle4) begin
                  MajorState <= controlPkg::Fetch;
                  SubCycle <= controlPkg::Cycle0;
               end else begin
                  SubCycle <= nextSub;
               end
            end
            default: begin
               MajorState <= controlPkg::Fetch;
               SubCycle <= controlPkg::Cycle0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* sequencer/controlDecoder.sv */
// Control output decoder
`timescale 1ns/1ns
`default_nettype none

module controlDecoder (
   input  controlPkg::majorStateT MajorState,
   input  controlPkg::subCycleT   SubCycle,
   input  isaPkg::opcodeT         Opcode,
   input  isaPkg::branchT         Branch,
   input  logic                   BranchTaken,
   output controlPkg::aluFnT      AluOp,
   output controlPkg::op1SelT     Op1Sel,
   output controlPkg::op2SelT     Op2Sel,
   output controlPkg::wdSelT      WdSel,
   output controlPkg::immSelT     ImmSel,
   output controlPkg::pcSelT      PcSel,
   output controlPkg::lrSelT      LrSel,
   output controlPkg::rs1SelT     Rs1Sel,
   output logic                   AluEn,
   output logic                   AluWe,
   output logic                   LrEn,
   output logic                   LrWe,
   output logic                   PcWe,
   output logic                   PcEn,
   output logic                   IrWe,
   output logic                   RegWe,
   output logic                   MemEn,
   output logic                   nWE,
   output logic                   nOE,
   output logic                   nME,
   output logic                   ENB,
   output logic                   ALE,
   output logic                   StatusWe,
   output logic                   IntClear,
   output logic                   IntEnable,
   output logic                   IntDisable
);

   // ALU function of a single cycle op
   function automatic controlPkg::aluFnT aluFunction(isaPkg::opcodeT op);
      case (op)
         isaPkg::ADD, isaPkg::ADDI, isaPkg::ADDIB: return controlPkg::FnADD;
         isaPkg::ADC, isaPkg::ADCI, isaPkg::SUC, isaPkg::SUCI: return controlPkg::FnADC;
         isaPkg::SUB, isaPkg::SUBI, isaPkg::SUBIB: return controlPkg::FnSUB;
         isaPkg::CMP, isaPkg::CMPI: return controlPkg::FnSUB;
         isaPkg::NEG:  return controlPkg::FnNEG;
         isaPkg::AND:  return controlPkg::FnAND;
         isaPkg::OR:   return controlPkg::FnOR;
         isaPkg::XOR:  return controlPkg::FnXOR;
         isaPkg::NOT:  return controlPkg::FnNOT;
         isaPkg::NAND: return controlPkg::FnNAND;
         isaPkg::NOR:  return controlPkg::FnNOR;
         isaPkg::LSL:  return controlPkg::FnLSL;
         isaPkg::LSR:  return controlPkg::FnLSR;
         isaPkg::ASR:  return controlPkg::FnASR;
         isaPkg::LUI:  return controlPkg::FnLUI;
         isaPkg::LLI:  return controlPkg::FnLLI;
         default:      return controlPkg::FnA;
      endcase
   endfunction

   always_comb begin
      AluOp = controlPkg::FnA;
      Op1Sel = controlPkg::Op1Rd1;
      Op2Sel = controlPkg::Op2Imm;
      WdSel = controlPkg::WdAlu;
      ImmSel = controlPkg::ImmLong;
      PcSel = controlPkg::Pc1;
      LrSel = controlPkg::LrSys;
      Rs1Sel = controlPkg::Rs1Ra;
      AluEn = 1'b0;
      AluWe = 1'b0;
      LrEn = 1'b0;
      LrWe = 1'b0;
      PcWe = 1'b0;
      PcEn = 1'b0;
      IrWe = 1'b0;
      RegWe = 1'b0;
      MemEn = 1'b0;
      nWE = 1'b0;
      nOE = 1'b0;
      nME = 1'b1;
      ENB = 1'b0;
      ALE = 1'b0;
      StatusWe = 1'b0;
      IntClear = 1'b0;
      IntEnable = 1'b0;
      IntDisable = 1'b0;
      case (MajorState)
         controlPkg::Fetch: begin
            case (SubCycle)
               controlPkg::Cycle0: begin  // pc out as address
                  ALE = 1'b1;
                  nWE = 1'b1;
                  nOE = 1'b1;
                  PcEn = 1'b1;
               end
               controlPkg::Cycle1: begin
                  nME = 1'b0;
                  nWE = 1'b1;
                  MemEn = 1'b1;
               end
               controlPkg::Cycle2: begin
                  nME = 1'b0;
                  nWE = 1'b1;
                  MemEn = 1'b1;
                  ENB = 1'b1;      // instruction on the bus
               end
               controlPkg::Cycle3: begin
                  nWE = 1'b1;
                  MemEn = 1'b1;
                  IrWe = 1'b1;
               end
               default: ;
            endcase
         end
         controlPkg::Execute: begin
            if (SubCycle == controlPkg::Cycle0) begin
               case (Opcode)
                  isaPkg::LDW, isaPkg::STW: begin  // address add
                     AluOp = controlPkg::FnADD;
                     ImmSel = controlPkg::ImmShort;
                     AluEn = 1'b1;
                     AluWe = 1'b1;
                  end
                  isaPkg::BRANCH: begin
                     PcWe = 1'b1;
                     case (Branch)
                        isaPkg::RET: begin  // return address from link register
                           LrEn = 1'b1;
                           PcSel = controlPkg::PcSysbus;
                        end
                        isaPkg::JMP: begin
                           AluOp = controlPkg::FnADD;
                           ImmSel = controlPkg::ImmShort;
                           PcSel = controlPkg::PcAluOut;
                        end
                        default: begin  // pc relative target
                           AluOp = controlPkg::FnADD;
                           Op1Sel = controlPkg::Op1Pc;
                           AluEn = 1'b1;
                           if (BranchTaken) begin
                              PcSel = controlPkg::PcAluOut;
                              LrWe = Branch == isaPkg::BWL;
                              LrSel = controlPkg::LrPc;
                           end
                        end
                     endcase
                  end
                  isaPkg::INTERRUPT: begin
                     PcWe = 1'b1;
                     PcEn = 1'b1;
                     IntEnable = Branch == isaPkg::CodeEi;
                     IntDisable = Branch == isaPkg::CodeDi;
                  end
                  default: begin  // alu, compare, shift, lui and lli
                     AluOp = aluFunction(Opcode);
                     PcEn = 1'b1;
                     PcWe = 1'b1;
                     StatusWe = 1'b1;
                     RegWe = !(Opcode inside {isaPkg::CMP, isaPkg::CMPI});
                     AluEn = Opcode inside {isaPkg::LUI, isaPkg::LLI};
                     case (Opcode)
                        isaPkg::ADD, isaPkg::ADC, isaPkg::SUB, isaPkg::SUC, isaPkg::CMP,
                        isaPkg::AND, isaPkg::OR, isaPkg::XOR, isaPkg::NAND, isaPkg::NOR:
                           Op2Sel = controlPkg::Op2Rd2;
                        isaPkg::ADDI, isaPkg::ADCI, isaPkg::SUBI, isaPkg::SUCI, isaPkg::CMPI,
                        isaPkg::LSL, isaPkg::LSR, isaPkg::ASR:
                           ImmSel = controlPkg::ImmShort;
                        isaPkg::ADDIB, isaPkg::SUBIB, isaPkg::LUI, isaPkg::LLI:
                           Rs1Sel = controlPkg::Rs1Rd;
                        default: ;
                     endcase
                  end
               endcase
            end else begin  // memory cycles of ldw and stw
               case (SubCycle)
                  controlPkg::Cycle1: begin
                     ALE = 1'b1;
                     nWE = 1'b1;
                     nOE = 1'b1;
                     AluOp = controlPkg::FnADD;
                     ImmSel = controlPkg::ImmShort;
                     AluEn = 1'b1;
                  end
                  controlPkg::Cycle2: begin  // store data through the alu
                     nME = 1'b0;
                     nWE = 1'b1;
                     nOE = Opcode == isaPkg::STW;
                     MemEn = Opcode == isaPkg::LDW;
                     Rs1Sel = controlPkg::Rs1Rd;
                     AluEn = 1'b1;
                     AluWe = 1'b1;
                  end
                  controlPkg::Cycle3: begin
                     nME = 1'b0;
                     nWE = Opcode == isaPkg::LDW;
                     nOE = Opcode == isaPkg::STW;
                     MemEn = Opcode == isaPkg::LDW;
                     ENB = Opcode == isaPkg::LDW;
                     AluEn = Opcode == isaPkg::STW;  // hold write data
                  end
                  controlPkg::Cycle4: begin
                     PcWe = 1'b1;
                     nWE = Opcode == isaPkg::LDW;
                     nOE = Opcode == isaPkg::STW;
                     MemEn = Opcode == isaPkg::LDW;
                     AluEn = Opcode == isaPkg::STW;
                     RegWe = Opcode == isaPkg::LDW;
                     WdSel = controlPkg::WdSys;
                  end
                  default: ;
               endcase
            end
         end
         controlPkg::Interrupt: begin
            case (SubCycle)
               controlPkg::Cycle0: begin  // stack pointer through the alu
                  Rs1Sel = controlPkg::Seven;
                  AluEn = 1'b1;
                  AluWe = 1'b1;
               end
               controlPkg::Cycle1: begin
                  Rs1Sel = controlPkg::Seven;
                  AluEn = 1'b1;
                  ALE = 1'b1;
                  nWE = 1'b1;
                  nOE = 1'b1;
               end
               controlPkg::Cycle2: begin
                  nME = 1'b0;
                  nWE = 1'b1;
                  nOE = 1'b1;
                  PcEn = 1'b1;
               end
               controlPkg::Cycle3: begin  // pc written to the stack
                  nME = 1'b0;
                  nOE = 1'b1;
                  PcEn = 1'b1;
               end
               controlPkg::Cycle4: begin
                  nOE = 1'b1;
                  PcEn = 1'b1;
                  PcWe = 1'b1;
                  PcSel = controlPkg::PcInt;
                  IntClear = 1'b1;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* source/control.sv */
// Processor control unit
`timescale 1ns/1ns
`default_nettype none

module control #(
   parameter int SyncStages = 2
) (
   input  wire  [7:0]                   OpcodeCondIn,
   input  wire  [isaPkg::FlagWidth-1:0] Flags,
   input  wire                          nIRQ,
   input  wire                          Clock,
   input  wire                          nReset,
   output controlPkg::aluFnT            AluOp,
   output controlPkg::op1SelT           Op1Sel,
   output controlPkg::op2SelT           Op2Sel,
   output controlPkg::wdSelT            WdSel,
   output controlPkg::immSelT           ImmSel,
   output controlPkg::pcSelT            PcSel,
   output controlPkg::lrSelT            LrSel,
   output controlPkg::rs1SelT           Rs1Sel,
   output logic                         AluEn,
   output logic                         AluWe,
   output logic                         LrEn,
   output logic                         LrWe,
   output logic                         PcWe,
   output logic                         PcEn,
   output logic                         IrWe,
   output logic                         RegWe,
   output logic                         MemEn,   // pad control
   output logic                         nWE,
   output logic                         nOE,
   output logic                         nME,
   output logic                         ENB,
   output logic                         ALE,
   output logic                         CFlag
);

   isaPkg::opcodeT opcode;
   isaPkg::branchT branch;
   controlPkg::majorStateT majorState;
   controlPkg::subCycleT subCycle;
   logic intReq;
   logic intClear;
   logic intEnable;
   logic intDisable;
   logic statusWe;
   logic branchTaken;

   assign opcode = isaPkg::opcodeT'(OpcodeCondIn[7:3]);
   assign branch = isaPkg::branchT'(OpcodeCondIn[2:0]);

   interruptLatch #(.SyncStages(SyncStages)) intLatch0 (
      .Clock, .nReset, .nIRQ,
      .IntClear(intClear), .IntEnable(intEnable), .IntDisable(intDisable),
      .IntReq(intReq)
   );

   statusFlags flags0 (
      .Clock, .nReset, .Flags,
      .StatusWe(statusWe), .Branch(branch),
      .BranchTaken(branchTaken), .CFlag
   );

   stateSequencer seq0 (
      .Clock, .nReset,
      .Opcode(opcode), .Branch(branch), .IntReq(intReq),
      .MajorState(majorState), .SubCycle(subCycle)
   );

   controlDecoder dec0 (
      .MajorState(majorState), .SubCycle(subCycle),
      .Opcode(opcode), .Branch(branch), .BranchTaken(branchTaken),
      .AluOp, .Op1Sel, .Op2Sel, .WdSel, .ImmSel, .PcSel, .LrSel, .Rs1Sel,
      .AluEn, .AluWe, .LrEn, .LrWe, .PcWe, .PcEn, .IrWe, .RegWe,
      .MemEn, .nWE, .nOE, .nME, .ENB, .ALE,
      .StatusWe(statusWe), .IntClear(intClear),
      .IntEnable(intEnable), .IntDisable(intDisable)
   );

endmodule

`default_nettype wire

/* bench/controlTb.sv */
// Control unit testbench
`timescale 1ns/1ns
`default_nettype none

module controlTb;

   localparam int DisabledPairs = 20;  // instruction pairs with interrupts off
   localparam int EnabledPairs = 4;
   localparam int TotalInstr = 6 + 4 * DisabledPairs + 2 * EnabledPairs;
   localparam int IntLimit = 2 * 9 + 5;  // clocks from EI to interrupt entry

   logic Clock;
   logic nReset;
   logic [7:0] OpcodeCondIn;
   logic [3:0] Flags;
   logic nIRQ;
   controlPkg::aluFnT AluOp;
   controlPkg::op1SelT Op1Sel;
   controlPkg::op2SelT Op2Sel;
   controlPkg::wdSelT WdSel;
   controlPkg::immSelT ImmSel;
   controlPkg::pcSelT PcSel;
   controlPkg::lrSelT LrSel;
   controlPkg::rs1SelT Rs1Sel;
   logic AluEn;
   logic AluWe;
   logic LrEn;
   logic LrWe;
   logic PcWe;
   logic PcEn;
   logic IrWe;
   logic RegWe;
   logic MemEn;
   logic nWE;
   logic nOE;
   logic nME;
   logic ENB;
   logic ALE;
   logic CFlag;

   logic [31:0] rngState;
   int cycleCount = 0;
   int lastIr = 0;
   int sinceIr = 100;  // clocks since the last IrWe
   int intSince = 0;   // entries since the last IrWe
   int intCount = 0;
   int waitCycles = 0;
   bit haveIr = 1'b0;
   bit afterReset = 1'b1;
   bit intEnabled = 1'b0;
   bit intWait = 1'b0;
   logic [3:0] statusModel = 4'h0;
   logic [3:0] aleHist = 4'h0;
   logic [3:0] pcEnHist = 4'h0;
   logic [3:0] nmeHist = 4'hf;
   logic [3:0] irHist = 4'h0;
   isaPkg::opcodeT execOp = isaPkg::ADD;
   isaPkg::branchT execCode = isaPkg::BR;

   control #(.SyncStages(2)) dut0 (.*);

   initial begin
      Clock = 1'b0;
      forever #2 Clock = ~Clock;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic bit branchRule(input isaPkg::branchT code, input logic [3:0] st);
      bit z;
      bit sameSign;
      z = st[isaPkg::FlagZ];
      sameSign = st[isaPkg::FlagN] == st[isaPkg::FlagV];  // no signed overflow of sign
      case (code)
         isaPkg::BR, isaPkg::BWL: return 1'b1;
         isaPkg::BE:  return z;
         isaPkg::BNE: return !z;
         isaPkg::BLT: return !sameSign;
         isaPkg::BGE: return sameSign;
         default:     return 1'b0;
      endcase
   endfunction

   function automatic controlPkg::aluFnT expectedFn(input isaPkg::opcodeT op);
      case (op)
         isaPkg::ADD, isaPkg::ADDI, isaPkg::ADDIB: return controlPkg::FnADD;
         isaPkg::ADC, isaPkg::ADCI: return controlPkg::FnADC;
         isaPkg::SUC, isaPkg::SUCI: return controlPkg::FnADC;  // borrow via carry adder
         isaPkg::SUB, isaPkg::SUBI, isaPkg::SUBIB: return controlPkg::FnSUB;
         isaPkg::CMP, isaPkg::CMPI: return controlPkg::FnSUB;
         isaPkg::NEG: return controlPkg::FnNEG;
         isaPkg::AND: return controlPkg::FnAND;
         isaPkg::OR: return controlPkg::FnOR;
         isaPkg::XOR: return controlPkg::FnXOR;
         isaPkg::NOT: return controlPkg::FnNOT;
         isaPkg::NAND: return controlPkg::FnNAND;
         isaPkg::NOR: return controlPkg::FnNOR;
         isaPkg::LSL: return controlPkg::FnLSL;
         isaPkg::LSR: return controlPkg::FnLSR;
         isaPkg::ASR: return controlPkg::FnASR;
         isaPkg::LUI: return controlPkg::FnLUI;
         isaPkg::LLI: return controlPkg::FnLLI;
         default: return controlPkg::FnA;
      endcase
   endfunction

   task automatic stopRun(input string reason);
      $display("%s", reason);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic checkEqual(input string name, input int got, input int exp);
      assert (got == exp) else
         stopRun($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
   endtask

   task automatic checkTrue(input bit cond, input string what);
      assert (cond) else stopRun($sformatf("%s at %0t ns", what, $time));
   endtask

   task automatic checkFetch;
      int expectedGap;
      expectedGap = (execOp inside {isaPkg::LDW, isaPkg::STW} ? 9 : 5) + 6 * intSince;
      checkEqual("ALE", int'(aleHist[2]), 1);  // address cycle of this fetch
      checkEqual("PcEn", int'(pcEnHist[2]), 1);
      checkEqual("nME", int'(nmeHist[1]), 0);
      checkEqual("nME", int'(nmeHist[0]), 0);
      if (haveIr) begin
         checkEqual("IrWe spacing", cycleCount - lastIr, expectedGap);
      end
      haveIr = 1'b1;
      lastIr = cycleCount;
      intSince = 0;
      sinceIr = 0;
      execOp = isaPkg::opcodeT'(OpcodeCondIn[7:3]);
      execCode = isaPkg::branchT'(OpcodeCondIn[2:0]);
   endtask

   task automatic checkExecute;
      bit taken;
      bit regOperand;
      taken = branchRule(execCode, statusModel);
      regOperand = execOp inside {isaPkg::ADD, isaPkg::ADC, isaPkg::SUB, isaPkg::SUC,
                                  isaPkg::CMP, isaPkg::AND, isaPkg::OR, isaPkg::XOR,
                                  isaPkg::NAND, isaPkg::NOR};
      case (execOp)
         isaPkg::LDW, isaPkg::STW: begin  // address add
            checkEqual("RegWe", int'(RegWe), 0);
            checkEqual("AluEn", int'(AluEn), 1);
            checkEqual("ImmSel", int'(ImmSel), int'(controlPkg::ImmShort));
         end
         isaPkg::BRANCH: begin
            checkEqual("PcWe", int'(PcWe), 1);
            if (execCode == isaPkg::RET) begin
               checkEqual("PcSel", int'(PcSel), int'(controlPkg::PcSysbus));
               checkEqual("LrEn", int'(LrEn), 1);
            end else if (execCode == isaPkg::JMP) begin
               checkEqual("PcSel", int'(PcSel), int'(controlPkg::PcAluOut));
            end else begin
               checkEqual("PcSel", int'(PcSel),
                          taken ? int'(controlPkg::PcAluOut) : int'(controlPkg::Pc1));
               checkEqual("Op1Sel", int'(Op1Sel), int'(controlPkg::Op1Pc));
            end
            checkEqual("LrWe", int'(LrWe), int'(taken && execCode == isaPkg::BWL));
            if (taken && execCode == isaPkg::BWL) begin
               checkEqual("LrSel", int'(LrSel), int'(controlPkg::LrPc));
            end
         end
         isaPkg::INTERRUPT: begin
            checkEqual("PcWe", int'(PcWe), 1);
            if (execCode == isaPkg::CodeEi) begin
               intEnabled = 1'b1;
               intWait = 1'b1;  // request already pending
               waitCycles = 0;
            end
            if (execCode == isaPkg::CodeDi) begin
               intEnabled = 1'b0;
            end
         end
         default: begin  // single cycle alu group
            checkEqual("PcWe", int'(PcWe), 1);
            checkEqual("PcSel", int'(PcSel), int'(controlPkg::Pc1));
            checkEqual("AluOp", int'(AluOp), int'(expectedFn(execOp)));
            checkEqual("RegWe", int'(RegWe),
                       int'(!(execOp inside {isaPkg::CMP, isaPkg::CMPI})));
            checkEqual("Op2Sel", int'(Op2Sel),
                       regOperand ? int'(controlPkg::Op2Rd2) : int'(controlPkg::Op2Imm));
            statusModel = Flags;  // loads on this edge
         end
      endcase
   endtask

   task automatic checkMemory;
      bit load;
      load = execOp == isaPkg::LDW;
      checkEqual("RegWe", int'(RegWe), int'(load && sinceIr == 5));
      if (sinceIr == 3 || sinceIr == 4) begin
         checkEqual("nME", int'(nME), 0);
      end
      if (load && sinceIr == 5) begin
         checkEqual("WdSel", int'(WdSel), int'(controlPkg::WdSys));
      end
   endtask

   task automatic checkBus;
      if (ALE) begin
         checkEqual("nME", int'(nME), 1);  // address cycle has no access
      end
      if (!nME) begin
         checkTrue(nWE || nOE, "read and write strobes low together");
      end
      if (ENB) begin
         checkTrue(MemEn && !nOE && !nME, "ENB outside a read access");
      end
   endtask

   task automatic checkEntry;
      if (PcWe && PcSel == controlPkg::PcInt) begin
         checkTrue(intEnabled, "interrupt entry while interrupts are disabled");
         checkTrue(!IrWe && irHist == 4'h0, "IrWe during the interrupt entry cycles");
         intCount++;
         intSince++;
         intWait = 1'b0;
      end else if (intWait) begin
         waitCycles++;
         checkTrue(waitCycles <= IntLimit, "no interrupt entry in time after EI");
      end
   endtask

   // outputs are sampled before the edge updates the state
   always @(posedge Clock) begin
      cycleCount++;
      if (!nReset) begin
         checkEqual("nME", int'(nME), 1);
         checkEqual("RegWe", int'(RegWe), 0);
         checkEqual("PcWe", int'(PcWe), 0);
         checkEqual("IrWe", int'(IrWe), 0);
         checkEqual("LrWe", int'(LrWe), 0);
         checkEqual("AluWe", int'(AluWe), 0);
      end else begin
         if (afterReset) begin
            checkEqual("ALE", int'(ALE), 1);  // fetch cycle 0
            checkEqual("nME", int'(nME), 1);
            afterReset = 1'b0;
         end
         checkEqual("CFlag", int'(CFlag), int'(statusModel[isaPkg::FlagC]));
         checkBus();
         if (IrWe) begin
            checkFetch();
         end else if (sinceIr < 100) begin
            sinceIr++;
         end
         if (sinceIr == 1) begin
            checkExecute();
         end
         if (execOp inside {isaPkg::LDW, isaPkg::STW} && sinceIr >= 1 && sinceIr <= 5) begin
            checkMemory();
         end
         if (!(sinceIr == 1 && execOp == isaPkg::BRANCH)) begin
            checkEqual("LrWe", int'(LrWe), 0);
         end
         checkEntry();
      end
      aleHist = {aleHist[2:0], ALE};
      pcEnHist = {pcEnHist[2:0], PcEn};
      nmeHist = {nmeHist[2:0], nME};
      irHist = {irHist[2:0], IrWe};
   end

   // next instruction register load, acknowledging an interrupt on the way
   task automatic waitFetch;
      do begin
         @(negedge Clock);
         if (Rs1Sel == controlPkg::Seven) begin
            nIRQ = 1'b1;  // stack access ends the request
         end
      end while (!IrWe);
   endtask

   task automatic issue(input isaPkg::opcodeT op, input logic [2:0] code,
                        input logic [3:0] flagValue);
      waitFetch();
      OpcodeCondIn = {op, code};
      Flags = flagValue;
   endtask

   task automatic issueRandom(input bit branch);
      isaPkg::opcodeT op;
      rngState = xorshift(rngState);
      op = branch ? isaPkg::BRANCH : isaPkg::opcodeT'(rngState[4:0] % 5'd27);
      issue(op, rngState[10:8], rngState[19:16]);
   endtask

   initial begin
      rngState = 32'h7797_1677;
      OpcodeCondIn = 8'h00;
      Flags = 4'h0;
      nIRQ = 1'b1;
      nReset = 1'b0;
      repeat (16) @(posedge Clock);
      @(negedge Clock);
      nReset = 1'b1;
      nIRQ = 1'b0;  // held while interrupts are off
      issue(isaPkg::LDW, 3'd0, 4'h0);
      issue(isaPkg::STW, 3'd0, 4'h0);
      issue(isaPkg::CMP, 3'd0, 4'hf);
      issue(isaPkg::CMPI, 3'd0, 4'h6);
      repeat (DisabledPairs) begin
         issueRandom(1'b0);
         issueRandom(1'b1);
      end
      issue(isaPkg::INTERRUPT, isaPkg::CodeEi, 4'h0);
      repeat (EnabledPairs) begin
         issueRandom(1'b0);
         issueRandom(1'b1);
      end
      checkTrue(intCount == 1, "expected exactly one interrupt entry after EI");
      issue(isaPkg::INTERRUPT, isaPkg::CodeDi, 4'h0);
      nIRQ = 1'b0;
      repeat (DisabledPairs) begin
         issueRandom(1'b0);
         issueRandom(1'b1);
      end
      waitFetch();
      @(posedge Clock);
      @(negedge Clock);
      $display("SIMULATION PASSED");
      $finish;
   end

   initial begin
      repeat (TotalInstr * 9 + 200) @(posedge Clock);
      stopRun("timeout, the instruction sequence did not finish");
   end

endmodule

`default_nettype wire

/* control.f */
common/isaPkg.sv
common/controlPkg.sv
source/interruptLatch.sv
source/statusFlags.sv
sequencer/stateSequencer.sv
sequencer/controlDecoder.sv
source/control.sv
bench/controlTb.sv

/* Makefile */
# Verilator build and run of the control unit testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module controlTb \
		-f control.f -Mdir obj_dir -o controlTb

run: compile
	./obj_dir/controlTb | tee sim.log
	grep -q "^SIMULATION PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
